//--- filelist.f
logic/decode_pkg.sv
logic/decode_if.sv
logic/prefix_scan.sv
logic/opcode_rom.sv
logic/field_extract.sv
logic/instr_length.sv
logic/decode_top.sv
verif/tb_clock.sv
verif/decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the decoder testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module decode_tb -f filelist.f -o decode_sim > build.log 2>&1 \
  || { cat build.log; echo "build error, see build.log"; exit 1; }

./obj_dir/decode_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation passed" sim.log \
  && echo "result: pass" \
  || { echo "result: fail, see sim.log"; exit 1; }

//--- verif/decode_tb.sv
// testbench for the two-stage x86 decoder with directed opcodes in random windows
// assertions check every result against a byte-walking model of the decode rules
`timescale 1ns/10ps

module decode_tb import decode_pkg::*; ();

  localparam int PERIOD     = 100;
  localparam int MAX_PREFIX = 4;
  localparam int PFX_RUNS   = 80;
  // reset, the five tests back to back, and a drain per test
  localparam int TEST_CYCLES = 2 + 9 + 16 + 96 + PFX_RUNS + 8 + 5 * 6;
  localparam int MARGIN      = 50;

  // escape, opcode, ModR/M present, immediate kind (0 none, 1 byte, 2 word)
  localparam logic [11:0] OP_TABLE [15] = '{
    {1'b0, 8'h90, 1'b0, 2'd0}, {1'b0, 8'hF4, 1'b0, 2'd0}, {1'b0, 8'hCF, 1'b0, 2'd0},
    {1'b0, 8'hC3, 1'b0, 2'd0}, {1'b0, 8'h01, 1'b1, 2'd0}, {1'b0, 8'h89, 1'b1, 2'd0},
    {1'b0, 8'h8B, 1'b1, 2'd0}, {1'b0, 8'h05, 1'b0, 2'd2}, {1'b0, 8'hB8, 1'b0, 2'd2},
    {1'b0, 8'h83, 1'b1, 2'd1}, {1'b0, 8'hC7, 1'b1, 2'd2}, {1'b0, 8'hE8, 1'b0, 2'd2},
    {1'b0, 8'hEB, 1'b0, 2'd1}, {1'b1, 8'h6F, 1'b1, 2'd0}, {1'b1, 8'h7F, 1'b1, 2'd0}
  };
  localparam byte_t PLAIN_OPS [8] = '{8'h90, 8'hF4, 8'hCF, 8'hE8, 8'hEB, 8'h05, 8'hB8, 8'hC3};
  localparam byte_t MODRM_OPS [3] = '{8'h8B, 8'h83, 8'hC7};
  localparam byte_t PFX_CODES [8] = '{8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65, 8'h66, 8'hF2};
  localparam byte_t PFX_OPS [6]   = '{8'h05, 8'hB8, 8'hC7, 8'h83, 8'h8B, 8'hE8};
  // last three follow a 0F escape
  localparam byte_t BAD_OPS [8]   = '{8'h00, 8'h14, 8'h8D, 8'hFF, 8'hCC, 8'h05, 8'hA2, 8'h90};

  typedef struct packed {
    byte_t opcode;
    byte_t modrm;
    byte_t sib;
    eip_t  disp32;
    eip_t  imm32;
    eip_t  next_eip;
    ilen_t length;
    logic  seg_over;
    seg_t  seg_reg;
    logic  size_over;
    logic  repne;
    logic  hlt;
    logic  iret;
    logic  illegal;
  } result_t;

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  window_t in_bytes;
  eip_t    in_eip;
  logic    out_valid;
  byte_t   out_opcode;
  byte_t   out_modrm;
  byte_t   out_sib;
  eip_t    out_disp32;
  eip_t    out_imm32;
  eip_t    out_next_eip;
  ilen_t   out_length;
  logic    out_seg_over;
  logic    out_size_over;
  logic    out_repne;
  logic    out_hlt;
  logic    out_iret;
  logic    out_illegal;
  seg_t    out_seg_reg;

  result_t got;
  result_t exp_cur;
  result_t exp_q [$];
  logic    have_exp;
  logic [1:0] vld_hist;
  byte_t   ib [WINDOW_BYTES];
  int      ib_len;
  int      seed;
  int      fail_count;
  int      check_count;
  int      sent;
  int      tests_run;
  int      sent_base;
  int      fail_base;

  tb_clock #(.PERIOD(PERIOD)) tb_clock_inst (.clk(clk));

  decode_top #(.MAX_PREFIX(MAX_PREFIX)) decode_top_inst (.*);

  // seg_reg only means something under an override
  assign got = {out_opcode, out_modrm, out_sib, out_disp32, out_imm32, out_next_eip, out_length,
                out_seg_over, out_seg_over ? out_seg_reg : 3'd0, out_size_over, out_repne,
                out_hlt, out_iret, out_illegal};

  function automatic int seg_index(input byte_t b);
    case (b)
      8'h26:   return 0;
      8'h2E:   return 1;
      8'h36:   return 2;
      8'h3E:   return 3;
      8'h64:   return 4;
      8'h65:   return 5;
      default: return -1;
    endcase
  endfunction

  function automatic void table_lookup(input logic esc, input byte_t op, output logic ok,
                                       output logic modrm_f, output logic [1:0] kind);
    ok      = 1'b0;
    modrm_f = 1'b0;
    kind    = 2'd0;
    for (int k = 0; k < 15; k++) begin
      if (OP_TABLE[k][11:3] == {esc, op}) begin
        ok      = 1'b1;
        modrm_f = OP_TABLE[k][2];
        kind    = OP_TABLE[k][1:0];
      end
    end
  endfunction

  // walks the window byte by byte the way the decode rules describe
  function automatic result_t decode_model(input window_t w, input eip_t eip);
    result_t    r;
    int         pos;
    int         sidx;
    int         disp_n;
    logic       esc;
    logic       scanning;
    logic       ok;
    logic       modrm_f;
    logic [1:0] kind;
    byte_t      b;
    r        = '0;
    pos      = 0;
    esc      = 1'b0;
    scanning = 1'b1;
    for (int i = 0; i < MAX_PREFIX; i++) begin
      b    = w[i*8 +: 8];
      sidx = seg_index(b);
      if (scanning && (sidx >= 0 || b == 8'h66 || b == 8'hF2 || b == 8'h0F)) begin
        pos = i + 1;
        if (sidx >= 0) begin
          r.seg_over = 1'b1;
          r.seg_reg  = seg_t'(sidx);
        end
        r.size_over = r.size_over | (b == 8'h66);
        r.repne     = r.repne | (b == 8'hF2);
        esc         = esc | (b == 8'h0F);
      end else begin
        scanning = 1'b0;
      end
    end
    r.opcode = w[pos*8 +: 8];
    pos++;
    table_lookup(esc, r.opcode, ok, modrm_f, kind);
    r.illegal = !ok;
    if (modrm_f) begin
      r.modrm = w[pos*8 +: 8];
      pos++;
      if (r.modrm[7:6] != 2'b11 && r.modrm[2:0] == 3'b100) begin
        r.sib = w[pos*8 +: 8];
        pos++;
      end
      case (r.modrm[7:6])
        2'b00:   disp_n = (r.modrm[2:0] == 3'b101) ? 4 : 0;
        2'b01:   disp_n = 1;
        2'b10:   disp_n = 4;
        default: disp_n = 0;
      endcase
      if (disp_n == 1) begin
        r.disp32 = {{24{w[pos*8+7]}}, w[pos*8 +: 8]};
      end else if (disp_n == 4) begin
        r.disp32 = w[pos*8 +: 32];
      end
      pos += disp_n;
    end
    if (kind == 2'd1) begin
      r.imm32 = {{24{w[pos*8+7]}}, w[pos*8 +: 8]};
      pos += 1;
    end else if (kind == 2'd2 && r.size_over) begin
      r.imm32 = {16'h0000, w[pos*8 +: 16]};
      pos += 2;
    end else if (kind == 2'd2) begin
      r.imm32 = w[pos*8 +: 32];
      pos += 4;
    end
    r.hlt      = ok && r.opcode == 8'hF4;
    r.iret     = ok && r.opcode == 8'hCF;
    r.length   = ilen_t'(pos);
    r.next_eip = eip + 32'(pos);
    return r;
  endfunction

  task automatic show_value(input string name, input logic [31:0] g, input logic [31:0] e);
    fail_count++;
    $display("[FAIL] %s got %h expected %h at %0t", name, g, e, $time);
  endtask

  task automatic report_diff(input result_t g, input result_t e);
    if (g.opcode !== e.opcode) show_value("out_opcode", 32'(g.opcode), 32'(e.opcode));
    if (g.modrm !== e.modrm) show_value("out_modrm", 32'(g.modrm), 32'(e.modrm));
    if (g.sib !== e.sib) show_value("out_sib", 32'(g.sib), 32'(e.sib));
    if (g.disp32 !== e.disp32) show_value("out_disp32", g.disp32, e.disp32);
    if (g.imm32 !== e.imm32) show_value("out_imm32", g.imm32, e.imm32);
    if (g.next_eip !== e.next_eip) show_value("out_next_eip", g.next_eip, e.next_eip);
    if (g.length !== e.length) show_value("out_length", 32'(g.length), 32'(e.length));
    if (g.seg_over !== e.seg_over) begin
      show_value("out_seg_over", 32'(g.seg_over), 32'(e.seg_over));
    end
    if (g.seg_reg !== e.seg_reg) show_value("out_seg_reg", 32'(g.seg_reg), 32'(e.seg_reg));
    if (g.size_over !== e.size_over) begin
      show_value("out_size_over", 32'(g.size_over), 32'(e.size_over));
    end
    if (g.repne !== e.repne) show_value("out_repne", 32'(g.repne), 32'(e.repne));
    if (g.hlt !== e.hlt) show_value("out_hlt", 32'(g.hlt), 32'(e.hlt));
    if (g.iret !== e.iret) show_value("out_iret", 32'(g.iret), 32'(e.iret));
    if (g.illegal !== e.illegal) show_value("out_illegal", 32'(g.illegal), 32'(e.illegal));
  endtask

  task automatic add_byte(input byte_t b);
    ib[ib_len] = b;
    ib_len++;
  endtask

  // random filler after the listed bytes, window held for one cycle
  task automatic issue();
    window_t w;
    eip_t    eip;
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      w[i*8 +: 8] = (i < ib_len) ? ib[i] : byte_t'($random(seed));
    end
    eip = $random(seed);
    @(negedge clk);
    in_valid = 1'b1;
    in_bytes = w;
    in_eip   = eip;
    exp_q.push_back(decode_model(w, eip));
    sent++;
    ib_len = 0;
  endtask

  task automatic send_op(input byte_t op);
    add_byte(op);
    issue();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    idle(1);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    idle(2);
    tests_run++;
    $display("test %0d %s: %0d instructions, %0d failures", tests_run, name,
             sent - sent_base, fail_count - fail_base);
    sent_base = sent;
    fail_base = fail_count;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      vld_hist <= 2'b00;
    end else begin
      vld_hist <= {vld_hist[0], in_valid};
    end
  end

  // pop the expected result for the rising edge that follows
  always @(negedge clk) begin
    have_exp = 1'b0;
    if (out_valid && exp_q.size() != 0) begin
      exp_cur  = exp_q.pop_front();
      have_exp = 1'b1;
      check_count++;
    end
  end

  a_valid_follow: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == vld_hist[1])
    else show_value("out_valid", 32'($sampled(out_valid)), 32'($sampled(vld_hist[1])));

  a_results: assert property (@(posedge clk) disable iff (!rst_n)
    have_exp |-> got == exp_cur)
    else report_diff($sampled(got), $sampled(exp_cur));

  initial begin
    #(PERIOD * (TEST_CYCLES + MARGIN));
    $display("watchdog expired after %0d cycles with results still pending",
             TEST_CYCLES + MARGIN);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    byte_t modrm;
    int    npfx;
    logic  esc_pick;
    seed        = 32'hf1ae_7c69;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_bytes    = '0;
    in_eip      = '0;
    have_exp    = 1'b0;
    ib_len      = 0;
    fail_count  = 0;
    check_count = 0;
    sent        = 0;
    tests_run   = 0;
    sent_base   = 0;
    fail_base   = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // quiet after reset, then single and back-to-back windows
    idle(3);
    send_op(8'h90);
    idle(2);
    send_op(8'h90);
    send_op(8'hC3);
    send_op(8'hF4);
    finish_test("reset and valid");

    for (int n = 0; n < 16; n++) begin
      send_op(PLAIN_OPS[n % 8]);
    end
    finish_test("no modrm");

    for (int op = 0; op < 3; op++) begin
      for (int m = 0; m < 32; m++) begin
        modrm      = byte_t'($random(seed));
        modrm[7:6] = m[4:3];
        modrm[2:0] = m[2:0];
        add_byte(MODRM_OPS[op]);
        add_byte(modrm);
        issue();
      end
    end
    finish_test("modrm forms");

    for (int n = 0; n < PFX_RUNS; n++) begin
      npfx     = {$random(seed)} % 5;
      esc_pick = ({$random(seed)} % 4 == 0) && npfx > 0;
      for (int s = 0; s < npfx; s++) begin
        if (esc_pick && s == npfx - 1) begin
          add_byte(8'h0F);
        end else begin
          add_byte(PFX_CODES[{$random(seed)} % 8]);
        end
      end
      if (esc_pick) begin
        send_op(n[0] ? 8'h6F : 8'h7F);
      end else begin
        send_op(PFX_OPS[{$random(seed)} % 6]);
      end
    end
    finish_test("prefixes");

    for (int k = 0; k < 8; k++) begin
      npfx = {$random(seed)} % 3;
      for (int s = 0; s < npfx; s++) begin
        add_byte(PFX_CODES[{$random(seed)} % 8]);
      end
      if (k >= 5) begin
        add_byte(8'h0F);
      end
      send_op(BAD_OPS[k]);
    end
    finish_test("illegal opcodes");

    $display("tests %0d, instructions %0d, checks %0d, failures %0d",
             tests_run, sent, check_count, fail_count);
    if (fail_count == 0 && check_count == sent) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verif/tb_clock.sv
// free-running testbench clock
// first rising edge comes half a period after time zero
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

//--- logic/decode_top.sv
// two-stage x86 decode: prefix scan, field extraction and length
// one window per cycle in, results two cycles later
`timescale 1ns/10ps

module decode_top import decode_pkg::*; #(
  parameter int MAX_PREFIX = 4
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  window_t in_bytes,
  input  eip_t    in_eip,
  output logic    out_valid,
  output byte_t   out_opcode,
  output byte_t   out_modrm,
  output byte_t   out_sib,
  output eip_t    out_disp32,
  output eip_t    out_imm32,
  output eip_t    out_next_eip,
  output ilen_t   out_length,
  output logic    out_seg_over,
  output logic    out_size_over,
  output logic    out_repne,
  output logic    out_hlt,
  output logic    out_iret,
  output logic    out_illegal,
  output seg_t    out_seg_reg
);

  prefix_if pfx_bus ();
  field_if  fld_bus ();

  byte_t     opcode;
  logic      has_modrm;
  imm_kind_t imm_kind;
  logic      legal;

  prefix_scan #(
    .MAX_PREFIX(MAX_PREFIX)
  ) prefix_scan_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_bytes (in_bytes),
    .in_eip   (in_eip),
    .pfx      (pfx_bus.source)
  );

  // escape flag comes straight from the prefix bus
  opcode_rom opcode_rom_inst (
    .opcode    (opcode),
    .esc_0f    (pfx_bus.esc_0f),
    .has_modrm (has_modrm),
    .imm_kind  (imm_kind),
    .legal     (legal)
  );

  field_extract #(
    .MAX_PREFIX(MAX_PREFIX)
  ) field_extract_inst (
    .pfx       (pfx_bus.sink),
    .has_modrm (has_modrm),
    .imm_kind  (imm_kind),
    .legal     (legal),
    .opcode    (opcode),
    .fld       (fld_bus.source)
  );

  instr_length instr_length_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pfx           (pfx_bus.sink),
    .fld           (fld_bus.sink),
    .out_valid     (out_valid),
    .out_opcode    (out_opcode),
    .out_modrm     (out_modrm),
    .out_sib       (out_sib),
    .out_disp32    (out_disp32),
    .out_imm32     (out_imm32),
    .out_next_eip  (out_next_eip),
    .out_length    (out_length),
    .out_seg_over  (out_seg_over),
    .out_size_over (out_size_over),
    .out_repne     (out_repne),
    .out_hlt       (out_hlt),
    .out_iret      (out_iret),
    .out_illegal   (out_illegal),
    .out_seg_reg   (out_seg_reg)
  );

endmodule

//--- logic/instr_length.sv
// second decode stage: instruction length, next EIP and the output register
// outputs are valid for one cycle, two cycles after in_valid at the top
`timescale 1ns/10ps

module instr_length import decode_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  prefix_if.sink pfx,
  field_if.sink  fld,
  output logic   out_valid,
  output byte_t  out_opcode,
  output byte_t  out_modrm,
  output byte_t  out_sib,
  output eip_t   out_disp32,
  output eip_t   out_imm32,
  output eip_t   out_next_eip,
  output ilen_t  out_length,
  output logic   out_seg_over,
  output logic   out_size_over,
  output logic   out_repne,
  output logic   out_hlt,
  output logic   out_iret,
  output logic   out_illegal,
  output seg_t   out_seg_reg
);

  ilen_t length;
  eip_t  next_eip;

  assign length   = pfx.prefix_count + fld.body_len;
  assign next_eip = pfx.eip + eip_t'(length);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pfx.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pfx.valid) begin
      out_opcode    <= fld.opcode;
      out_modrm     <= fld.modrm;
      out_sib       <= fld.sib;
      out_disp32    <= fld.disp32;
      out_imm32     <= fld.imm32;
      out_next_eip  <= next_eip;
      out_length    <= length;
      out_seg_over  <= pfx.seg_over;
      out_seg_reg   <= pfx.seg_reg;
      out_size_over <= pfx.size_over;
      out_repne     <= pfx.repne;
      out_hlt       <= fld.hlt;
      out_iret      <= fld.iret;
      out_illegal   <= fld.illegal;
    end
  end

  // every decoded instruction covers at least its opcode byte
  a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> out_length != 4'd0);

endmodule

//--- logic/field_extract.sv
// picks the opcode after the prefixes and aligns ModR/M, SIB, displacement
// and immediate, combinational between the two register stages
`timescale 1ns/10ps

module field_extract import decode_pkg::*; #(
  parameter int MAX_PREFIX = 4
) (
  prefix_if.sink   pfx,
  input  logic      has_modrm,
  input  imm_kind_t imm_kind,
  input  logic      legal,
  output byte_t     opcode,
  field_if.source  fld
);

  logic        use_modrm;
  logic        sib_present;
  logic [1:0]  mod_f;
  logic [2:0]  rm_f;
  ilen_t       modrm_pos;
  ilen_t       disp_pos;
  ilen_t       imm_pos;
  ilen_t       disp_len;
  ilen_t       imm_len;
  logic [31:0] modrm_dw;
  logic [31:0] disp_raw;
  logic [31:0] imm_raw;

  // four bytes starting at a byte offset in the window
  function automatic logic [31:0] dword_at(input window_t w, input ilen_t pos);
    window_t shifted;
    shifted = w >> {pos, 3'b000};
    return shifted[31:0];
  endfunction

  // opcode sits right after the prefixes, slot 0 to MAX_PREFIX
  always_comb begin
    opcode = pfx.window[7:0];
    for (int i = 1; i <= MAX_PREFIX; i++) begin
      if (pfx.prefix_count == ilen_t'(i)) begin
        opcode = pfx.window[i*8 +: 8];
      end
    end
  end

  assign use_modrm = legal & has_modrm;
  assign modrm_pos = pfx.prefix_count + 4'd1;
  assign modrm_dw  = dword_at(pfx.window, modrm_pos);
  assign mod_f     = modrm_dw[7:6];
  assign rm_f      = modrm_dw[2:0];

  // SIB follows ModR/M for rm 100 in any memory form
  assign sib_present = use_modrm && (mod_f != 2'b11) && (rm_f == 3'b100);

  always_comb begin
    disp_len = 4'd0;
    if (use_modrm) begin
      case (mod_f)
        2'b00:   disp_len = (rm_f == 3'b101) ? 4'd4 : 4'd0;
        2'b01:   disp_len = 4'd1;
        2'b10:   disp_len = 4'd4;
        default: disp_len = 4'd0;
      endcase
    end
  end

  // operand-size override halves imm_word
  always_comb begin
    imm_len = 4'd0;
    if (legal) begin
      case (imm_kind)
        imm_byte: imm_len = 4'd1;
        imm_word: imm_len = pfx.size_over ? 4'd2 : 4'd4;
        default:  imm_len = 4'd0;
      endcase
    end
  end

  assign disp_pos = modrm_pos + 4'd1 + ilen_t'(sib_present);
  assign imm_pos  = use_modrm ? disp_pos + disp_len : modrm_pos;
  assign disp_raw = dword_at(pfx.window, disp_pos);
  assign imm_raw  = dword_at(pfx.window, imm_pos);

  always_comb begin
    case (disp_len)
      4'd1:    fld.disp32 = {{24{disp_raw[7]}}, disp_raw[7:0]};
      4'd4:    fld.disp32 = disp_raw;
      default: fld.disp32 = '0;
    endcase
    case (imm_len)
      4'd1:    fld.imm32 = {{24{imm_raw[7]}}, imm_raw[7:0]};
      4'd2:    fld.imm32 = {16'h0000, imm_raw[15:0]};
      4'd4:    fld.imm32 = imm_raw;
      default: fld.imm32 = '0;
    endcase
  end

  assign fld.opcode   = opcode;
  assign fld.modrm    = use_modrm ? modrm_dw[7:0] : 8'h00;
  assign fld.sib      = sib_present ? modrm_dw[15:8] : 8'h00;
  // opcode byte, ModR/M, SIB, displacement, immediate
  assign fld.body_len = 4'd1 + ilen_t'(use_modrm) + ilen_t'(sib_present) + disp_len + imm_len;
  assign fld.hlt      = legal && (opcode == op_hlt);
  assign fld.iret     = legal && (opcode == op_iret);
  assign fld.illegal  = ~legal;

endmodule

//--- logic/opcode_rom.sv
// reduced opcode table for the decoder
// keyed by the 0F escape and the opcode byte, purely combinational
`timescale 1ns/10ps

module opcode_rom import decode_pkg::*; (
  input  byte_t     opcode,
  input  logic      esc_0f,
  output logic      has_modrm,
  output imm_kind_t imm_kind,
  output logic      legal
);

  always_comb begin
    has_modrm = 1'b0;
    imm_kind  = imm_none;
    legal     = 1'b1;
    if (esc_0f) begin
      // two-byte map, only the MMX moves
      case (opcode)
        8'h6F, 8'h7F: has_modrm = 1'b1;
        default:      legal     = 1'b0;
      endcase
    end else begin
      case (opcode)
        // nop, ret and the flagged ones
        8'h90, 8'hC3, op_hlt, op_iret: begin
          has_modrm = 1'b0;
        end
        // add and mov forms with ModR/M only
        8'h01, 8'h89, 8'h8B: begin
          has_modrm = 1'b1;
        end
        // add eax, mov eax, call rel32
        8'h05, 8'hB8, 8'hE8: begin
          imm_kind = imm_word;
        end
        // jmp rel8
        8'hEB: begin
          imm_kind = imm_byte;
        end
        // group 1 with imm8
        8'h83: begin
          has_modrm = 1'b1;
          imm_kind  = imm_byte;
        end
        // mov r/m, imm32
        8'hC7: begin
          has_modrm = 1'b1;
          imm_kind  = imm_word;
        end
        default: begin
          legal = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- logic/prefix_scan.sv
// first decode stage: registers the fetch window and finds the leading prefixes
// results go out on prefix_if one cycle after in_valid
`timescale 1ns/10ps

module prefix_scan import decode_pkg::*; #(
  parameter int MAX_PREFIX = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  window_t  in_bytes,
  input  eip_t     in_eip,
  prefix_if.source pfx
);

  logic    valid_q;
  window_t window_q;
  eip_t    eip_q;

  // per-slot matches
  logic [MAX_PREFIX-1:0] is_seg;
  logic [MAX_PREFIX-1:0] is_size;
  logic [MAX_PREFIX-1:0] is_repne;
  logic [MAX_PREFIX-1:0] is_esc;
  logic [MAX_PREFIX-1:0] is_pfx;
  logic [MAX_PREFIX-1:0] therm;
  seg_t                  slot_seg [MAX_PREFIX];

  ilen_t count;
  seg_t  seg_win;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      window_q <= in_bytes;
      eip_q    <= in_eip;
    end
  end

  always_comb begin
    byte_t slot_byte;
    for (int i = 0; i < MAX_PREFIX; i++) begin
      slot_byte   = window_q[i*8 +: 8];
      is_seg[i]   = 1'b1;
      slot_seg[i] = seg_es;
      case (slot_byte)
        pfx_es:  slot_seg[i] = seg_es;
        pfx_cs:  slot_seg[i] = seg_cs;
        pfx_ss:  slot_seg[i] = seg_ss;
        pfx_ds:  slot_seg[i] = seg_ds;
        pfx_fs:  slot_seg[i] = seg_fs;
        pfx_gs:  slot_seg[i] = seg_gs;
        default: is_seg[i]   = 1'b0;
      endcase
      is_size[i]  = (slot_byte == pfx_opsize);
      is_repne[i] = (slot_byte == pfx_repne);
      is_esc[i]   = (slot_byte == pfx_0f);
      is_pfx[i]   = is_seg[i] | is_size[i] | is_repne[i] | is_esc[i];
    end
  end

  // thermometer of consecutive prefixes from slot 0
  always_comb begin
    therm[0] = is_pfx[0];
    for (int i = 1; i < MAX_PREFIX; i++) begin
      therm[i] = therm[i-1] & is_pfx[i];
    end
  end

  // count and winning segment, later slots are nearer the opcode
  always_comb begin
    count   = '0;
    seg_win = seg_ds;
    for (int i = 0; i < MAX_PREFIX; i++) begin
      count = count + ilen_t'(therm[i]);
      if (therm[i] && is_seg[i]) begin
        seg_win = slot_seg[i];
      end
    end
  end

  assign pfx.valid        = valid_q;
  assign pfx.window       = window_q;
  assign pfx.eip          = eip_q;
  assign pfx.prefix_count = count;
  assign pfx.seg_over     = |(is_seg & therm);
  assign pfx.seg_reg      = seg_win;
  assign pfx.size_over    = |(is_size & therm);
  assign pfx.esc_0f       = |(is_esc & therm);
  assign pfx.repne        = |(is_repne & therm);

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    valid_q |-> count <= ilen_t'(MAX_PREFIX));

endmodule

//--- logic/decode_if.sv
// buses between the decode stages
// prefix_if leaves the input register, field_if leaves the field aligner
`timescale 1ns/10ps

interface prefix_if import decode_pkg::*; ();

  logic    valid;
  window_t window;
  eip_t    eip;
  ilen_t   prefix_count;
  logic    seg_over;
  seg_t    seg_reg;
  logic    size_over;
  logic    esc_0f;
  logic    repne;

  modport source (output valid, window, eip, prefix_count, seg_over, seg_reg,
                  size_over, esc_0f, repne);
  modport sink (input valid, window, eip, prefix_count, seg_over, seg_reg,
                size_over, esc_0f, repne);

endinterface

interface field_if import decode_pkg::*; ();

  byte_t opcode;
  byte_t modrm;
  byte_t sib;
  eip_t  disp32;
  eip_t  imm32;
  // bytes after the prefixes
  ilen_t body_len;
  logic  hlt;
  logic  iret;
  logic  illegal;

  modport source (output opcode, modrm, sib, disp32, imm32, body_len, hlt, iret, illegal);
  modport sink (input opcode, modrm, sib, disp32, imm32, body_len, hlt, iret, illegal);

endinterface

//--- logic/decode_pkg.sv
// shared types and byte codes for the two-stage x86 decode pipeline
// every decode module and both interfaces import this package
package decode_pkg;

  // fetch window size in bytes
  localparam int WINDOW_BYTES = 16;

  typedef logic [7:0]                byte_t;
  typedef logic [WINDOW_BYTES*8-1:0] window_t;
  typedef logic [31:0]               eip_t;
  typedef logic [3:0]                ilen_t;
  typedef logic [2:0]                seg_t;

  // immediate kind from the opcode table
  // imm_word is 4 bytes, or 2 under the 66 override
  typedef enum logic [1:0] {
    imm_none = 2'd0,
    imm_byte = 2'd1,
    imm_word = 2'd2
  } imm_kind_t;

  // segment override prefixes
  localparam byte_t pfx_cs = 8'h2E;
  localparam byte_t pfx_ss = 8'h36;
  localparam byte_t pfx_ds = 8'h3E;
  localparam byte_t pfx_es = 8'h26;
  localparam byte_t pfx_fs = 8'h64;
  localparam byte_t pfx_gs = 8'h65;

  // operand size, repne and two-byte escape
  localparam byte_t pfx_opsize = 8'h66;
  localparam byte_t pfx_repne  = 8'hF2;
  localparam byte_t pfx_0f     = 8'h0F;

  // opcodes flagged on the outputs
  localparam byte_t op_hlt  = 8'hF4;
  localparam byte_t op_iret = 8'hCF;

  // segment register numbering
  localparam seg_t seg_es = 3'd0;
  localparam seg_t seg_cs = 3'd1;
  localparam seg_t seg_ss = 3'd2;
  localparam seg_t seg_ds = 3'd3;
  localparam seg_t seg_fs = 3'd4;
  localparam seg_t seg_gs = 3'd5;

endpackage
